// ==== Makefile ====
# Verilator build and run for the mesh router testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= mesh_router_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ** PASS **

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@grep -qxF '$(PASS_MSG)' $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
verilog/noc_pkg.sv
verilog/input_queue.sv
verilog/route_calc.sv
verilog/switch_alloc.sv
verilog/crossbar_onehot.sv
verilog/mesh_router.sv
verif/mesh_router_assertions.sv
verif/mesh_router_tb.sv

// ==== verif/mesh_router_assertions.sv ====
// Switch allocator assertions
// Grant legality checks, bound into every switch_alloc instance

module mesh_router_assertions (
  input logic                                        clk,
  input logic                                        reset_n,
  input noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] i_output_req,   // [input][output]
  input noc_pkg::port_vec_t                          i_en,           // Downstream enables
  input noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] i_output_grant, // [output][input]
  input noc_pkg::port_vec_t                          i_input_grant   // Queue dequeues
);

  localparam int N = noc_pkg::NUM_PORTS;

  // ------------------------------------------------------------------------
  // Per output
  // ------------------------------------------------------------------------
  for (genvar o = 0; o < N; o++) begin : g_output
    a_grant_onehot : assert property (@(posedge clk) disable iff (!reset_n)
      $onehot0(i_output_grant[o]))                   // At most one winner
      else $error("Output %0d grant %b is not one-hot", o, i_output_grant[o]);

    a_grant_enabled : assert property (@(posedge clk) disable iff (!reset_n)
      !i_en[o] |-> (i_output_grant[o] == '0))        // Closed output stays idle
      else $error("Output %0d granted while its enable is low", o);
  end

  // Dequeue only behind a live request
  for (genvar i = 0; i < N; i++) begin : g_input
    a_input_req : assert property (@(posedge clk) disable iff (!reset_n)
      i_input_grant[i] |-> (i_output_req[i] != '0))
      else $error("Input %0d dequeued without a request", i);
  end

endmodule

bind switch_alloc mesh_router_assertions u_assertions (
  .clk            (clk),
  .reset_n        (reset_n),
  .i_output_req   (i_output_req),
  .i_en           (i_en),
  .i_output_grant (o_output_grant),
  .i_input_grant  (o_input_grant)
);

// ==== verif/mesh_router_tb.sv ====
// Mesh router testbench
// Random single-flit traffic on all five inputs under random downstream
// back-pressure, checked against one FIFO model per input/output pair

module mesh_router_tb;

  localparam int N              = noc_pkg::NUM_PORTS;
  localparam int X_LOC          = 2;                 // Router sits at (2,2)
  localparam int Y_LOC          = 2;
  localparam int QUEUE_DEPTH    = 4;
  localparam int INJECT_CYCLES  = 2000;              // Cycles of random traffic
  localparam int DRAIN_CYCLES   = 2000;              // Allowance to empty the router
  localparam int TIMEOUT_CYCLES = 2 * INJECT_CYCLES + DRAIN_CYCLES;
  localparam int MAX_WAIT       = 4;                 // Grants to others while requesting
  localparam logic [noc_pkg::COORD_W-1:0] HOME_X = noc_pkg::COORD_W'(X_LOC);
  localparam logic [noc_pkg::COORD_W-1:0] HOME_Y = noc_pkg::COORD_W'(Y_LOC);

  logic                   clk;
  logic                   reset_n;
  noc_pkg::flit_t [N-1:0] i_data;
  noc_pkg::port_vec_t     i_data_val;
  noc_pkg::port_vec_t     i_en;                      // Downstream enables
  noc_pkg::port_vec_t     o_en;                      // Queue not full
  noc_pkg::flit_t [N-1:0] o_data;
  noc_pkg::port_vec_t     o_data_val;

  integer                    seed;
  int                        cycle_count;
  bit                        first_sample;           // First cycle out of reset
  logic [noc_pkg::SEQ_W-1:0] seq_tag [N];            // Next tag per input
  noc_pkg::flit_t            model_q [N*N][$];       // [input*N + output], oldest first
  int                        route_q [N][$];         // Outputs of flits held per input
  int                        wait_cnt [N][N];        // [output][input]

  mesh_router #(
    .X_LOC       (X_LOC),
    .Y_LOC       (Y_LOC),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_dut (
    .clk        (clk),
    .reset_n    (reset_n),
    .i_data     (i_data),
    .i_data_val (i_data_val),
    .o_en       (o_en),
    .o_data     (o_data),
    .o_data_val (o_data_val),
    .i_en       (i_en)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;                              // Period 8

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------
  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // XY rule, X first, then Y, then eject at home
  function automatic noc_pkg::port_e expected_output(input noc_pkg::flit_t f);
    noc_pkg::port_e port;
    port = noc_pkg::PORT_LOCAL;
    if (f.dest_x > HOME_X) begin
      port = noc_pkg::PORT_EAST;
    end else if (f.dest_x < HOME_X) begin
      port = noc_pkg::PORT_WEST;
    end else if (f.dest_y > HOME_Y) begin
      port = noc_pkg::PORT_NORTH;
    end else if (f.dest_y < HOME_Y) begin
      port = noc_pkg::PORT_SOUTH;
    end
    return port;
  endfunction

  function automatic bit model_empty();
    for (int k = 0; k < N * N; k++) begin
      if (model_q[k].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_flit(input string name, input noc_pkg::flit_t expected,
                            input noc_pkg::flit_t got);
    if (got !== expected) begin
      stop_on_error($sformatf("FAIL %s expected %h got %h", name, expected, got));
    end
  endtask

  task automatic check_port(input string name, input noc_pkg::port_e expected,
                            input noc_pkg::port_e got);
    if (got !== expected) begin
      stop_on_error($sformatf("FAIL %s expected %h got %h", name, expected, got));
    end
  endtask

  task automatic check_en(input string name, input noc_pkg::port_vec_t expected,
                          input noc_pkg::port_vec_t got);
    if (got !== expected) begin
      stop_on_error($sformatf("FAIL %s expected %h got %h", name, expected, got));
    end
  endtask

  // New random offer on every input, new random enable on every output
  task automatic drive_inputs();
    for (int p = 0; p < N; p++) begin
      i_data[p].dest_x   = noc_pkg::COORD_W'(rand_below(5));   // 5x5 mesh
      i_data[p].dest_y   = noc_pkg::COORD_W'(rand_below(5));
      i_data[p].src_port = noc_pkg::port_e'(noc_pkg::PORT_W'(p));
      i_data[p].seq      = seq_tag[p];
      i_data[p].payload  = noc_pkg::PAYLOAD_W'(rand_below(65536));
      i_data_val[p]      = (rand_below(2) == 0);
      i_en[p]            = (rand_below(4) != 0);                // 75 % open
      seq_tag[p]         = seq_tag[p] + noc_pkg::SEQ_W'(1);     // Refused offers too
    end
  endtask

  // ------------------------------------------------------------------------
  // Scoreboard, sampled mid-cycle for the coming rising edge
  // ------------------------------------------------------------------------
  task automatic sample_cycle();
    noc_pkg::port_vec_t requesting [N];             // [output], one bit per input
    noc_pkg::port_vec_t en_expected;
    noc_pkg::flit_t     f;
    noc_pkg::flit_t     expected;
    int                 src;
    int                 q;
    for (int o = 0; o < N; o++) begin
      requesting[o] = '0;
    end
    for (int i = 0; i < N; i++) begin              // Head of each queue per model
      if (route_q[i].size() != 0) begin
        requesting[route_q[i][0]][i] = 1'b1;
      end
    end
    // Not full per model occupancy, low in the first cycle out of reset
    for (int i = 0; i < N; i++) begin
      en_expected[i] = !first_sample && (route_q[i].size() < QUEUE_DEPTH);
    end
    check_en("o_en", en_expected, o_en);
    first_sample = 1'b0;
    for (int o = 0; o < N; o++) begin
      src = -1;
      if (o_data_val[o] && !i_en[o]) begin
        stop_on_error($sformatf("Output %0d showed a flit while its enable was low", o));
      end
      if (o_data_val[o]) begin
        f   = o_data[o];
        src = int'(f.src_port);
        if (src >= N) begin
          stop_on_error($sformatf("Output %0d carried a flit with no valid source", o));
        end
        check_port($sformatf("o_data[%0d] route", o), expected_output(f),
                   noc_pkg::port_e'(noc_pkg::PORT_W'(o)));
        q = src * N + o;
        if (model_q[q].size() == 0) begin
          stop_on_error($sformatf("Output %0d delivered a flit from input %0d %s",
                                  o, src, "that was never accepted or is a duplicate"));
        end
        expected = model_q[q].pop_front();
        check_flit($sformatf("o_data[%0d]", o), expected, f);
        void'(route_q[src].pop_front());
      end
      // Waiting inputs count grants to others
      if (i_en[o]) begin
        for (int i = 0; i < N; i++) begin
          if (!requesting[o][i] || i == src) begin
            wait_cnt[o][i] = 0;
          end else if (src >= 0) begin
            wait_cnt[o][i]++;
            if (wait_cnt[o][i] > MAX_WAIT) begin
              stop_on_error($sformatf("Input %0d waited more than %0d grants on output %0d",
                                      i, MAX_WAIT, o));
            end
          end
        end
      end
    end
    for (int i = 0; i < N; i++) begin              // Accepted transfers only
      if (i_data_val[i] && o_en[i]) begin
        q = i * N + int'(expected_output(i_data[i]));
        model_q[q].push_back(i_data[i]);
        route_q[i].push_back(int'(expected_output(i_data[i])));
      end
    end
  endtask

  always @(negedge clk) begin
    if (reset_n) begin
      sample_cycle();
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with flits still in the router", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  end

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    seed         = 32'h1e6da1ef;
    cycle_count  = 0;
    first_sample = 1'b1;
    reset_n      = 1'b0;
    i_data       = '0;
    i_data_val   = '0;
    i_en         = '0;
    for (int p = 0; p < N; p++) begin
      seq_tag[p] = '0;
      for (int k = 0; k < N; k++) begin
        wait_cnt[p][k] = 0;
      end
    end
    repeat (2) @(posedge clk);                     // Two cycles in reset
    #1 reset_n = 1'b1;
    repeat (INJECT_CYCLES) begin
      @(posedge clk);
      #1 drive_inputs();
    end
    @(posedge clk);
    #1;
    i_data_val = '0;                               // Stop offering, open every output
    i_en       = '1;
    while (!model_empty()) begin
      @(posedge clk);
    end
    repeat (10) @(posedge clk);                    // Late duplicates would show here
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== verilog/crossbar_onehot.sv ====
// One-hot crossbar
// Each output takes the head flit of the input named by its select
// vector, zero when nothing is selected

module crossbar_onehot (
  input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] i_sel,      // [output][input]
  input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] i_data,     // Queue heads
  output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] o_data,     // To downstream
  output noc_pkg::port_vec_t                          o_data_val  // Output carries a flit
);

  localparam int N = noc_pkg::NUM_PORTS;

  always_comb begin
    for (int o = 0; o < N; o++) begin
      o_data[o] = '0;                        // Quiet bus when unselected
      for (int i = 0; i < N; i++) begin
        if (i_sel[o][i]) begin
          o_data[o] = i_data[i];
        end
      end
      o_data_val[o] = |i_sel[o];             // Select is one-hot or zero
    end
  end

endmodule

// ==== verilog/input_queue.sv ====
// Input queue
// Circular flit buffer in front of one router input
// Upstream sees a registered not-full enable, the allocator pops the head

module input_queue #(
  parameter int DEPTH = 4                  // Flit slots, at least 2
) (
  input  logic           clk,
  input  logic           reset_n,
  input  noc_pkg::flit_t i_data,           // From upstream router or core
  input  logic           i_data_val,       // Upstream offers a flit
  input  logic           i_en,             // Dequeue from allocator
  output noc_pkg::flit_t o_data,           // Head flit
  output logic           o_data_val,       // Head holds a flit
  output logic           o_en              // Not full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT  = CNT_W'(DEPTH);

  noc_pkg::flit_t   mem [DEPTH];           // Flit storage
  logic [PTR_W-1:0] rd_ptr;                // Head slot
  logic [PTR_W-1:0] wr_ptr;                // Next free slot
  logic [CNT_W-1:0] count;                 // Occupancy
  logic [CNT_W-1:0] count_next;
  logic             push;
  logic             pop;

  assign push       = i_data_val & o_en;   // Accepted transfer
  assign pop        = i_en & o_data_val;   // Never pop an empty queue
  assign o_data     = mem[rd_ptr];
  assign o_data_val = (count != '0);

  // Occupancy after this edge
  always_comb begin
    count_next = count;
    if (push && !pop) begin
      count_next = count + CNT_W'(1);
    end else if (pop && !push) begin
      count_next = count - CNT_W'(1);
    end
  end

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

  // ------------------------------------------------------------------------
  // Pointers, count and enable
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      o_en   <= 1'b0;                      // Held low one cycle past reset
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_W'(1);
      end
      count <= count_next;
      o_en  <= (count_next != FULL_CNT);   // Full blocks push even with a pop
    end
  end

endmodule

// ==== verilog/mesh_router.sv ====
// Mesh router
// Five-port input-buffered router for a 2-D mesh with XY routing
// Path per flit is queue, route, allocate, switch

module mesh_router #(
  parameter int X_LOC       = 0,           // Column of this node
  parameter int Y_LOC       = 0,           // Row of this node
  parameter int QUEUE_DEPTH = 4            // Slots per input queue
) (
  input  logic                                        clk,
  input  logic                                        reset_n,

  // ------------------------------------------------------------------------
  // Upstream side [local, north, east, south, west]
  // ------------------------------------------------------------------------
  input  noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] i_data,
  input  noc_pkg::port_vec_t                          i_data_val,
  output noc_pkg::port_vec_t                          o_en,        // Queue not full

  // ------------------------------------------------------------------------
  // Downstream side [local, north, east, south, west]
  // ------------------------------------------------------------------------
  output noc_pkg::flit_t     [noc_pkg::NUM_PORTS-1:0] o_data,
  output noc_pkg::port_vec_t                          o_data_val,
  input  noc_pkg::port_vec_t                          i_en         // Neighbour can take a flit
);

  localparam int N = noc_pkg::NUM_PORTS;

  noc_pkg::flit_t     [N-1:0] head_data;     // Queue heads into crossbar
  noc_pkg::port_vec_t         head_val;      // Queue heads valid
  noc_pkg::port_vec_t [N-1:0] output_req;    // [input][output]
  noc_pkg::port_vec_t [N-1:0] output_grant;  // [output][input]
  noc_pkg::port_vec_t         input_grant;   // Dequeue per input

  // Queue and route calculator per input
  for (genvar i = 0; i < N; i++) begin : g_input
    input_queue #(
      .DEPTH (QUEUE_DEPTH)
    ) u_input_queue (
      .clk        (clk),
      .reset_n    (reset_n),
      .i_data     (i_data[i]),
      .i_data_val (i_data_val[i]),
      .i_en       (input_grant[i]),      // Pops on grant
      .o_data     (head_data[i]),
      .o_data_val (head_val[i]),
      .o_en       (o_en[i])
    );

    route_calc #(
      .X_LOC (X_LOC),
      .Y_LOC (Y_LOC)
    ) u_route_calc (
      .i_data       (head_data[i]),
      .i_val        (head_val[i]),
      .o_output_req (output_req[i])
    );
  end

  // Arbitration gated by downstream enables
  switch_alloc u_switch_alloc (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_output_req   (output_req),
    .i_en           (i_en),
    .o_output_grant (output_grant),
    .o_input_grant  (input_grant)
  );

  // Granted heads onto the outputs
  crossbar_onehot u_crossbar (
    .i_sel      (output_grant),
    .i_data     (head_data),
    .o_data     (o_data),
    .o_data_val (o_data_val)
  );

endmodule

// ==== verilog/noc_pkg.sv ====
// NoC shared definitions
// Port numbering, field widths and the single-flit packet format
// used by every block of the mesh router

package noc_pkg;

  // ------------------------------------------------------------------------
  // Sizes
  // ------------------------------------------------------------------------
  localparam int NUM_PORTS = 5;   // Local, north, east, south, west
  localparam int PORT_W    = 3;   // Bits to hold a port number
  localparam int COORD_W   = 3;   // Up to an 8x8 mesh
  localparam int SEQ_W     = 8;   // Sequence tag
  localparam int PAYLOAD_W = 16;  // User data

  // Port names, value doubles as bit index in request/grant vectors
  typedef enum logic [PORT_W-1:0] {
    PORT_LOCAL = 3'd0,            // Attached core
    PORT_NORTH = 3'd1,            // Towards larger y
    PORT_EAST  = 3'd2,            // Towards larger x
    PORT_SOUTH = 3'd3,            // Towards smaller y
    PORT_WEST  = 3'd4             // Towards smaller x
  } port_e;

  // ------------------------------------------------------------------------
  // Flit format
  // ------------------------------------------------------------------------
  // One flit is a whole packet. Fields pass through the router untouched
  typedef struct packed {
    logic [COORD_W-1:0]   dest_x;   // Destination column
    logic [COORD_W-1:0]   dest_y;   // Destination row
    port_e                src_port; // Set by sender
    logic [SEQ_W-1:0]     seq;      // Per-sender tag
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

  // One bit per port, indexed by port_e
  typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage

// ==== verilog/route_calc.sv ====
// Route calculator
// Dimension-ordered XY routing of the flit at a queue head
// Produces a one-hot output request, all zero when the head is empty

module route_calc #(
  parameter int X_LOC = 0,                 // This router's column
  parameter int Y_LOC = 0                  // This router's row
) (
  input  noc_pkg::flit_t     i_data,       // Head flit
  input  logic               i_val,        // Head valid
  output noc_pkg::port_vec_t o_output_req  // One-hot requested output
);

  localparam logic [noc_pkg::COORD_W-1:0] X_COORD = X_LOC[noc_pkg::COORD_W-1:0];
  localparam logic [noc_pkg::COORD_W-1:0] Y_COORD = Y_LOC[noc_pkg::COORD_W-1:0];

  logic go_east;                           // Destination column is larger
  logic go_west;
  logic go_north;                          // Destination row is larger
  logic go_south;

  assign go_east  = (i_data.dest_x > X_COORD);
  assign go_west  = (i_data.dest_x < X_COORD);
  assign go_north = (i_data.dest_y > Y_COORD);
  assign go_south = (i_data.dest_y < Y_COORD);

  // ------------------------------------------------------------------------
  // X first, then Y, then eject
  // ------------------------------------------------------------------------
  always_comb begin
    o_output_req = '0;
    if (i_val) begin
      if (go_east) begin
        o_output_req[noc_pkg::PORT_EAST] = 1'b1;
      end else if (go_west) begin
        o_output_req[noc_pkg::PORT_WEST] = 1'b1;
      end else if (go_north) begin       // Column reached
        o_output_req[noc_pkg::PORT_NORTH] = 1'b1;
      end else if (go_south) begin
        o_output_req[noc_pkg::PORT_SOUTH] = 1'b1;
      end else begin
        o_output_req[noc_pkg::PORT_LOCAL] = 1'b1;  // Arrived
      end
    end
  end

endmodule

// ==== verilog/switch_alloc.sv ====
// Switch allocator
// One round-robin arbiter per output, active only while the downstream
// neighbour enables that output. Grants are combinational, pointers move
// on the edge after a grant

module switch_alloc (
  input  logic                                        clk,
  input  logic                                        reset_n,
  input  noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] i_output_req,   // [input][output]
  input  noc_pkg::port_vec_t                          i_en,           // Downstream enables
  output noc_pkg::port_vec_t [noc_pkg::NUM_PORTS-1:0] o_output_grant, // [output][input]
  output noc_pkg::port_vec_t                          o_input_grant   // Queue dequeues
);

  localparam int N = noc_pkg::NUM_PORTS;

  noc_pkg::port_vec_t [N-1:0]         req_col;    // Requests seen by each output
  noc_pkg::port_e                     rr_ptr [N]; // First input to consider
  logic [noc_pkg::PORT_W-1:0]         grant_idx [N];

  // Input after the granted one, wrapping past the west port
  function automatic noc_pkg::port_e next_port(input logic [noc_pkg::PORT_W-1:0] idx);
    logic [noc_pkg::PORT_W-1:0] nxt;
    nxt = (idx == noc_pkg::PORT_W'(N - 1)) ? '0 : idx + noc_pkg::PORT_W'(1);
    return noc_pkg::port_e'(nxt);
  endfunction

  // Transpose, rows become outputs
  always_comb begin
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        req_col[o][i] = i_output_req[i][o];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Arbitration
  // ------------------------------------------------------------------------
  always_comb begin
    int   idx;
    logic found;
    idx   = 0;
    found = 1'b0;
    for (int o = 0; o < N; o++) begin
      o_output_grant[o] = '0;
      grant_idx[o]      = rr_ptr[o];
      found             = 1'b0;
      for (int k = 0; k < N; k++) begin
        idx = int'(rr_ptr[o]) + k;           // Search from the pointer
        if (idx >= N) begin
          idx = idx - N;
        end
        if (!found && i_en[o] && req_col[o][idx]) begin
          found                  = 1'b1;     // Lowest distance from pointer wins
          o_output_grant[o][idx] = 1'b1;
          grant_idx[o]           = noc_pkg::PORT_W'(idx);
        end
      end
    end
  end

  // One output per input, so OR collapses the column
  always_comb begin
    o_input_grant = '0;
    for (int o = 0; o < N; o++) begin
      for (int i = 0; i < N; i++) begin
        o_input_grant[i] = o_input_grant[i] | o_output_grant[o][i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Round-robin pointers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      for (int o = 0; o < N; o++) begin
        rr_ptr[o] <= noc_pkg::PORT_LOCAL;
      end
    end else begin
      for (int o = 0; o < N; o++) begin
        if (|o_output_grant[o]) begin        // Idle outputs keep their pointer
          rr_ptr[o] <= next_port(grant_idx[o]);
        end
      end
    end
  end

endmodule
